/* src/cpuPkg.sv */
package cpuPkg;

    // ----------------------------------------------------------------------
    // widths and memory sizes
    // ----------------------------------------------------------------------

    // data and address word
    localparam int XLEN       = 32;
    // instruction rom words
    localparam int IMEM_DEPTH = 64;
    // data ram words, addressed by bits 11:2
    localparam int DMEM_DEPTH = 1024;
    localparam int SWITCH_W   = 12;
    localparam int LED_W      = 16;

    // ----------------------------------------------------------------------
    // io address map
    // ----------------------------------------------------------------------

    // upper 22 address bits all ones select io space
    localparam logic [21:0] IO_BASE       = 22'h3F_FFFF;
    // low 10 bit offsets inside io space
    localparam logic [9:0]  IO_SWITCH_OFS = 10'h070;
    localparam logic [9:0]  IO_LED_OFS    = 10'h060;
    localparam logic [9:0]  IO_SEG_OFS    = 10'h000;

    // ----------------------------------------------------------------------
    // opcodes and alu codes
    // ----------------------------------------------------------------------

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // main decode class, refined in the alu
    localparam logic [1:0] ALUOP_ADD    = 2'b00;
    localparam logic [1:0] ALUOP_BRANCH = 2'b01;
    localparam logic [1:0] ALUOP_FUNCT  = 2'b10;

    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SUB = 4'b0110;

endpackage

/* src/instFetch.sv */
`timescale 1ns/1ps

module instFetch
    import cpuPkg::*;
(
    input  logic            cpu_clk,
    input  logic            rstN_i,
    input  logic            branchTaken_i,
    input  logic [XLEN-1:0] immediate_i,
    output logic [XLEN-1:0] inst_o,
    output logic [XLEN-1:0] pcPlus4_o
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] instRom [IMEM_DEPTH];

    // program image, one word per line
    initial begin
        $readmemh("src/prog.hex", instRom);
    end

    // ----------------------------------------------------------------------
    // next pc
    // ----------------------------------------------------------------------

    assign pcPlus4_o = pc + 32'd4;

    // branch offset is already pc relative, taken decision comes from controller
    assign pcNext = branchTaken_i ? (pc + immediate_i) : pcPlus4_o;

    always_ff @(posedge cpu_clk) begin
        if (!rstN_i) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // word index into rom, byte offset bits dropped
    assign inst_o = instRom[pc[$clog2(IMEM_DEPTH)+1:2]];

endmodule

/* src/instDecode.sv */
`timescale 1ns/1ps

module instDecode
    import cpuPkg::*;
(
    input  logic            cpu_clk,
    input  logic            rstN_i,
    input  logic [XLEN-1:0] inst_i,
    input  logic            regWrite_i,
    input  logic            memToReg_i,
    input  logic [XLEN-1:0] aluResult_i,
    input  logic [XLEN-1:0] loadData_i,
    output logic [XLEN-1:0] readData1_o,
    output logic [XLEN-1:0] readData2_o,
    output logic [XLEN-1:0] immediate_o
);

    logic [XLEN-1:0] regFile [32];
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [6:0]      opcode;
    logic [XLEN-1:0] wbData;

    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign rd     = inst_i[11:7];
    assign opcode = inst_i[6:0];

    // ----------------------------------------------------------------------
    // register file
    // ----------------------------------------------------------------------

    // loads write back memory or io data, the rest the alu result
    assign wbData = memToReg_i ? loadData_i : aluResult_i;

    always_ff @(posedge cpu_clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (regWrite_i && (rd != 5'd0)) begin
            regFile[rd] <= wbData;
        end
    end

    // x0 reads as zero
    assign readData1_o = (rs1 == 5'd0) ? '0 : regFile[rs1];
    assign readData2_o = (rs2 == 5'd0) ? '0 : regFile[rs2];

    // ----------------------------------------------------------------------
    // immediate generation
    // ----------------------------------------------------------------------

    always_comb begin
        case (opcode)
            // s type, split field
            OPC_STORE:  immediate_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            // b type, offset in halfwords
            OPC_BRANCH: immediate_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                                       inst_i[30:25], inst_i[11:8], 1'b0};
            // i type covers loads and alu immediates
            default:    immediate_o = {{20{inst_i[31]}}, inst_i[31:20]};
        endcase
    end

endmodule

/* src/controller.sv */
`timescale 1ns/1ps

module controller
    import cpuPkg::*;
(
    input  logic [XLEN-1:0] inst_i,
    input  logic            zero_i,
    input  logic [XLEN-1:0] aluResult_i,
    output logic [1:0]      aluOp_o,
    output logic            aluSrc_o,
    output logic            memRead_o,
    output logic            memWrite_o,
    output logic            memToReg_o,
    output logic            regWrite_o,
    output logic            ioRead_o,
    output logic            ioWrite_o,
    output logic            branchTaken_o
);

    logic [6:0] opcode;
    logic       isLoad;
    logic       isStore;
    logic       isRType;
    logic       isIType;
    logic       isBranch;
    logic       ioAddr;

    assign opcode = inst_i[6:0];

    // ----------------------------------------------------------------------
    // opcode classes
    // ----------------------------------------------------------------------

    assign isLoad   = (opcode == OPC_LOAD);
    assign isStore  = (opcode == OPC_STORE);
    assign isRType  = (opcode == OPC_RTYPE);
    assign isIType  = (opcode == OPC_ITYPE);
    assign isBranch = (opcode == OPC_BRANCH);

    // effective address lands in io space
    assign ioAddr = (aluResult_i[XLEN-1:10] == IO_BASE);

    // immediate operand for address calc and alu immediates
    assign aluSrc_o   = isLoad | isStore | isIType;
    assign memToReg_o = isLoad;
    assign regWrite_o = isLoad | isRType | isIType;

    // memory access split between ram and io
    assign memRead_o  = isLoad & ~ioAddr;
    assign ioRead_o   = isLoad & ioAddr;
    assign memWrite_o = isStore & ~ioAddr;
    assign ioWrite_o  = isStore & ioAddr;

    always_comb begin
        if (isRType || isIType) begin
            aluOp_o = ALUOP_FUNCT;
        end else if (isBranch) begin
            aluOp_o = ALUOP_BRANCH;
        end else begin
            aluOp_o = ALUOP_ADD;
        end
    end

    // beq only, taken when rs1 - rs2 is zero
    assign branchTaken_o = isBranch & (inst_i[14:12] == 3'b000) & zero_i;

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
    import cpuPkg::*;
(
    input  logic [XLEN-1:0] readData1_i,
    input  logic [XLEN-1:0] readData2_i,
    input  logic [XLEN-1:0] immediate_i,
    input  logic            aluSrc_i,
    input  logic [1:0]      aluOp_i,
    input  logic [2:0]      funct3_i,
    input  logic [6:0]      funct7_i,
    output logic [XLEN-1:0] aluResult_o,
    output logic            zero_o
);

    logic [3:0]      aluCtrl;
    logic [XLEN-1:0] operandB;

    // ----------------------------------------------------------------------
    // alu control
    // ----------------------------------------------------------------------

    always_comb begin
        aluCtrl = ALU_ADD;
        case (aluOp_i)
            ALUOP_BRANCH: aluCtrl = ALU_SUB;
            ALUOP_FUNCT: begin
                case (funct3_i)
                    // funct7 only meaningful for r type, imm bits otherwise
                    3'b000:  aluCtrl = (!aluSrc_i && funct7_i[5]) ? ALU_SUB : ALU_ADD;
                    3'b110:  aluCtrl = ALU_OR;
                    3'b111:  aluCtrl = ALU_AND;
                    default: aluCtrl = ALU_ADD;
                endcase
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------

    assign operandB = aluSrc_i ? immediate_i : readData2_i;

    always_comb begin
        case (aluCtrl)
            ALU_SUB: aluResult_o = readData1_i - operandB;
            ALU_AND: aluResult_o = readData1_i & operandB;
            ALU_OR:  aluResult_o = readData1_i | operandB;
            default: aluResult_o = readData1_i + operandB;
        endcase
    end

    assign zero_o = (aluResult_o == '0);

endmodule

/* src/dataMem.sv */
`timescale 1ns/1ps

module dataMem
    import cpuPkg::*;
(
    input  logic                          cpu_clk,
    input  logic                          writeEn_i,
    input  logic [$clog2(DMEM_DEPTH)-1:0] addr_i,
    input  logic [XLEN-1:0]               writeData_i,
    output logic [XLEN-1:0]               readData_o
);

    // word ram, contents undefined until written
    logic [XLEN-1:0] ram [DMEM_DEPTH];

    // store lands at the edge that ends the instruction
    always_ff @(posedge cpu_clk) begin
        if (writeEn_i) begin
            ram[addr_i] <= writeData_i;
        end
    end

    // load data ready in the same cycle
    assign readData_o = ram[addr_i];

endmodule

/* src/memOrIo.sv */
`timescale 1ns/1ps

module memOrIo
    import cpuPkg::*;
(
    input  logic                cpu_clk,
    input  logic                rstN_i,
    input  logic                memWrite_i,
    input  logic                ioRead_i,
    input  logic                ioWrite_i,
    input  logic [XLEN-1:0]     addr_i,
    input  logic [XLEN-1:0]     memData_i,
    input  logic [XLEN-1:0]     storeData_i,
    input  logic [SWITCH_W-1:0] switchData_i,
    output logic [XLEN-1:0]     loadData_o,
    output logic                ramWe_o,
    output logic [LED_W-1:0]    ledData_o,
    output logic                ledWe_o,
    output logic [XLEN-1:0]     segData_o,
    output logic                segWe_o
);

    logic [9:0] ioOfs;

    assign ioOfs   = addr_i[9:0];
    assign ramWe_o = memWrite_i;

    // ----------------------------------------------------------------------
    // load path
    // ----------------------------------------------------------------------

    always_comb begin
        loadData_o = memData_i;
        if (ioRead_i) begin
            case (ioOfs)
                IO_SWITCH_OFS: loadData_o = {{(XLEN-SWITCH_W){1'b0}}, switchData_i};
                // output registers read back as well
                IO_LED_OFS:    loadData_o = {{(XLEN-LED_W){1'b0}}, ledData_o};
                IO_SEG_OFS:    loadData_o = segData_o;
                default:       loadData_o = '0;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // store path
    // ----------------------------------------------------------------------

    // write pulses high for the whole store cycle
    assign ledWe_o = ioWrite_i && (ioOfs == IO_LED_OFS);
    assign segWe_o = ioWrite_i && (ioOfs == IO_SEG_OFS);

    always_ff @(posedge cpu_clk) begin
        if (!rstN_i) begin
            ledData_o <= '0;
            segData_o <= '0;
        end else begin
            // led keeps the low half of the store word
            if (ledWe_o) begin
                ledData_o <= storeData_i[LED_W-1:0];
            end
            if (segWe_o) begin
                segData_o <= storeData_i;
            end
        end
    end

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
    import cpuPkg::*;
(
    input  logic                cpu_clk,
    input  logic                rstN_i,
    input  logic [SWITCH_W-1:0] switchData_i,
    output logic [LED_W-1:0]    ledData_o,
    output logic                ledWe_o,
    output logic [XLEN-1:0]     segData_o,
    output logic                segWe_o
);

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------

    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] immediate32;
    logic [XLEN-1:0] readData1;
    logic [XLEN-1:0] readData2;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] memData;
    logic [XLEN-1:0] loadData;
    logic [1:0]      aluOp;
    logic            aluSrc;
    logic            memWrite;
    logic            memToReg;
    logic            regWrite;
    logic            ioRead;
    logic            ioWrite;
    logic            zero;
    logic            branchTaken;
    logic            ramWe;

    // ----------------------------------------------------------------------
    // instances
    // ----------------------------------------------------------------------

    // no jal, so the return address stays unused
    instFetch i_instFetch (
        .cpu_clk       (cpu_clk),
        .rstN_i        (rstN_i),
        .branchTaken_i (branchTaken),
        .immediate_i   (immediate32),
        .inst_o        (inst),
        .pcPlus4_o     ()
    );

    instDecode i_instDecode (
        .cpu_clk     (cpu_clk),
        .rstN_i      (rstN_i),
        .inst_i      (inst),
        .regWrite_i  (regWrite),
        .memToReg_i  (memToReg),
        .aluResult_i (aluResult),
        .loadData_i  (loadData),
        .readData1_o (readData1),
        .readData2_o (readData2),
        .immediate_o (immediate32)
    );

    // ram read is asynchronous and always on, read strobe left open
    controller i_controller (
        .inst_i        (inst),
        .zero_i        (zero),
        .aluResult_i   (aluResult),
        .aluOp_o       (aluOp),
        .aluSrc_o      (aluSrc),
        .memRead_o     (),
        .memWrite_o    (memWrite),
        .memToReg_o    (memToReg),
        .regWrite_o    (regWrite),
        .ioRead_o      (ioRead),
        .ioWrite_o     (ioWrite),
        .branchTaken_o (branchTaken)
    );

    alu i_alu (
        .readData1_i (readData1),
        .readData2_i (readData2),
        .immediate_i (immediate32),
        .aluSrc_i    (aluSrc),
        .aluOp_i     (aluOp),
        .funct3_i    (inst[14:12]),
        .funct7_i    (inst[31:25]),
        .aluResult_o (aluResult),
        .zero_o      (zero)
    );

    // word address from byte address bits 11:2
    dataMem i_dataMem (
        .cpu_clk     (cpu_clk),
        .writeEn_i   (ramWe),
        .addr_i      (aluResult[$clog2(DMEM_DEPTH)+1:2]),
        .writeData_i (readData2),
        .readData_o  (memData)
    );

    memOrIo i_memOrIo (
        .cpu_clk      (cpu_clk),
        .rstN_i       (rstN_i),
        .memWrite_i   (memWrite),
        .ioRead_i     (ioRead),
        .ioWrite_i    (ioWrite),
        .addr_i       (aluResult),
        .memData_i    (memData),
        .storeData_i  (readData2),
        .switchData_i (switchData_i),
        .loadData_o   (loadData),
        .ramWe_o      (ramWe),
        .ledData_o    (ledData_o),
        .ledWe_o      (ledWe_o),
        .segData_o    (segData_o),
        .segWe_o      (segWe_o)
    );

endmodule

/* bench/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb
    import cpuPkg::*;
();

    // ----------------------------------------------------------------------
    // run length
    // ----------------------------------------------------------------------

    localparam int    NUM_FIXED      = 6;
    localparam int    NUM_RANDOM     = 20;
    localparam int    NUM_VALS       = NUM_FIXED + NUM_RANDOM;
    localparam int    CLK_PERIOD_NS  = 4;
    // worst case pass is 4095 loop iterations of 4 instructions plus the frame
    localparam int    ITERS_PER_PASS = 4100;
    localparam int    INSTR_PER_ITER = 4;
    localparam longint MARGIN_NS     = 20000;
    localparam longint WATCHDOG_NS   =
        longint'(NUM_VALS) * ITERS_PER_PASS * INSTR_PER_ITER * CLK_PERIOD_NS + MARGIN_NS;

    logic                cpu_clk;
    logic                rstN_i;
    logic [SWITCH_W-1:0] switchData_i;
    logic [LED_W-1:0]    ledData_o;
    logic                ledWe_o;
    logic [XLEN-1:0]     segData_o;
    logic                segWe_o;

    // monitor state
    logic                monitorOn;
    logic                segPending;
    logic                ledPending;
    logic [XLEN-1:0]     expSeg;
    logic [LED_W-1:0]    expLed;
    logic [XLEN-1:0]     heldSeg;
    logic [LED_W-1:0]    heldLed;
    int                  segSinceLed;
    int                  ledCount;
    int                  seed;
    logic [SWITCH_W-1:0] switchVals [$];

    cpuTop i_dut (
        .cpu_clk      (cpu_clk),
        .rstN_i       (rstN_i),
        .switchData_i (switchData_i),
        .ledData_o    (ledData_o),
        .ledWe_o      (ledWe_o),
        .segData_o    (segData_o),
        .segWe_o      (segWe_o)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) cpu_clk = ~cpu_clk;
    end

    // ----------------------------------------------------------------------
    // reference model and compare tasks
    // ----------------------------------------------------------------------

    // closed form sum of 1..n and the led value (sum - n) & 0x7ff
    function automatic void computeExpected(input logic [SWITCH_W-1:0] n,
                                            output logic [XLEN-1:0] sumO,
                                            output logic [LED_W-1:0] ledO);
        longint unsigned full;
        logic [XLEN-1:0] diff;
        full = longint'(n) * (longint'(n) + 1) / 2;
        sumO = full[XLEN-1:0];
        diff = (sumO - XLEN'(n)) & 32'h0000_07FF;
        ledO = diff[LED_W-1:0];
    endfunction

    task automatic checkSeg(input string sigName, input logic [XLEN-1:0] act,
                            input logic [XLEN-1:0] exp);
        if (act !== exp) begin
            $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, sigName, act, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkLed(input string sigName, input logic [LED_W-1:0] act,
                            input logic [LED_W-1:0] exp);
        if (act !== exp) begin
            $display("ERR %0t %s got 0x%04h expected 0x%04h", $time, sigName, act, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkPulse(input string sigName, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, sigName, act, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic reportSequenceError(input string what);
        $display("pulse order broken at %0t: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped at pulse order error");
    endtask

    // outputs while in reset and right after it
    task automatic checkIdleOutputs();
        checkPulse("ledWe_o", ledWe_o, 1'b0);
        checkPulse("segWe_o", segWe_o, 1'b0);
        checkLed("ledData_o", ledData_o, '0);
        checkSeg("segData_o", segData_o, '0);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] rnd;
        rstN_i       = 1'b0;
        switchData_i = '0;
        monitorOn    = 1'b0;
        seed         = 43353;
        switchVals   = '{12'd0, 12'd1, 12'd2, 12'd5, 12'd12, 12'd4095};
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            switchVals.push_back(rnd[SWITCH_W-1:0]);
        end
        // first value is up before the first fetch
        switchData_i = switchVals[0];
        repeat (2) begin
            @(negedge cpu_clk);
            checkIdleOutputs();
        end
        rstN_i <= 1'b1;
        @(negedge cpu_clk);
        checkIdleOutputs();
        monitorOn <= 1'b1;
        // new switch value once the led of the previous pass is checked
        for (int i = 0; i < NUM_VALS; i++) begin
            if (i > 0) begin
                @(negedge cpu_clk);
                switchData_i <= switchVals[i];
            end
            wait (ledCount == i + 1);
        end
        $display("All tests passed!");
        $finish;
    end

    // ----------------------------------------------------------------------
    // monitor sampling on the falling edge
    // ----------------------------------------------------------------------

    initial begin
        segPending  = 1'b0;
        ledPending  = 1'b0;
        heldSeg     = '0;
        heldLed     = '0;
        expSeg      = '0;
        expLed      = '0;
        segSinceLed = 0;
        ledCount    = 0;
    end

    always @(negedge cpu_clk) begin
        if (monitorOn) begin
            // register written at the edge after the pulse
            if (segPending) begin
                checkSeg("segData_o", segData_o, expSeg);
                heldSeg    = segData_o;
                segPending = 1'b0;
            end else begin
                checkSeg("segData_o", segData_o, heldSeg);
            end
            if (ledPending) begin
                checkLed("ledData_o", ledData_o, expLed);
                heldLed    = ledData_o;
                ledPending = 1'b0;
                ledCount++;
            end else begin
                checkLed("ledData_o", ledData_o, heldLed);
            end
            // one display write then one led write per pass
            if (segWe_o) begin
                if (segSinceLed != 0) begin
                    reportSequenceError("second display write before the led write");
                end
                computeExpected(switchData_i, expSeg, expLed);
                segSinceLed = 1;
                segPending  = 1'b1;
            end
            if (ledWe_o) begin
                if (segSinceLed != 1) begin
                    reportSequenceError("led write without a display write before it");
                end
                segSinceLed = 0;
                ledPending  = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, not all switch values finished a pass in time");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

endmodule

/* src/prog.hex */
// one 32-bit instruction per line, word address 0 first
C0000093
0700A103
000001B3
00010233
00020863
004181B3
FFF20213
FE000AE3
00302023
00002303
0060A023
402303B3
7FF3F393
0670A023
FC0006E3
00000000

/* list.f */
src/cpuPkg.sv
src/instFetch.sv
src/instDecode.sv
src/controller.sv
src/alu.sv
src/dataMem.sv
src/memOrIo.sv
src/cpuTop.sv
bench/cpuTb.sv

/* Bender.yml */
package:
  name: rv32i_subset_cpu

sources:
  # processor sources, package first
  - src/cpuPkg.sv
  - src/instFetch.sv
  - src/instDecode.sv
  - src/controller.sv
  - src/alu.sv
  - src/dataMem.sv
  - src/memOrIo.sv
  - src/cpuTop.sv

  # testbench
  - target: test
    files:
      - bench/cpuTb.sv
